//--- l1_pkg.sv
package l1_pkg;

    // Address and data geometry
    localparam int ADDR_W         = 16;
    localparam int DATA_W         = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W         = 128;
    localparam int WAYS           = 2;
    localparam int SETS           = 16;
    localparam int OFFSET_W       = 4;
    localparam int WORD_SEL_W     = 2;
    localparam int SET_W          = 4;
    localparam int TAG_W          = ADDR_W - SET_W - OFFSET_W;
    localparam int WAY_W          = 1;

    // Controller FSM encoding
    localparam int STATE_W      = 3;
    localparam int ST_IDLE      = 0;
    localparam int ST_LOOKUP    = 1;
    localparam int ST_RESPOND   = 2;
    localparam int ST_WB_REQ    = 3;
    localparam int ST_FILL_REQ  = 4;
    localparam int ST_FILL_WAIT = 5;

    // One line seen as a bus word or as four port words with word 0 in the low bits
    typedef union packed {
        logic [LINE_W-1:0]                     flat;
        logic [WORDS_PER_LINE-1:0][DATA_W-1:0] words;
    } line_u;

    function automatic logic [TAG_W-1:0] addr_tag(input logic [ADDR_W-1:0] addr);
        return addr[ADDR_W-1 -: TAG_W];
    endfunction

    function automatic logic [SET_W-1:0] addr_set(input logic [ADDR_W-1:0] addr);
        return addr[OFFSET_W +: SET_W];
    endfunction

    function automatic logic [WORD_SEL_W-1:0] addr_word(input logic [ADDR_W-1:0] addr);
        return addr[OFFSET_W-1 -: WORD_SEL_W];
    endfunction

    function automatic logic [ADDR_W-1:0] line_addr(input logic [TAG_W-1:0] tag,
                                                    input logic [SET_W-1:0] set);
        return {tag, set, {OFFSET_W{1'b0}}};
    endfunction

endpackage

//--- l1_line_store.sv
`timescale 1ns/1ns

module l1_line_store (
    input  logic                        clk_i,
    input  logic [l1_pkg::ADDR_W-1:0]   addr_i,
    input  logic [l1_pkg::WAY_W-1:0]    way_i,
    input  logic                        word_wr_i,
    input  logic [l1_pkg::DATA_W-1:0]   word_data_i,
    input  logic                        fill_i,
    input  l1_pkg::line_u               fill_line_i,
    output l1_pkg::line_u               rd_line_o
);

    l1_pkg::line_u                   mem_q [l1_pkg::SETS][l1_pkg::WAYS];

    logic [l1_pkg::SET_W-1:0]        set;
    logic [l1_pkg::WORD_SEL_W-1:0]   word;

    assign set  = l1_pkg::addr_set(addr_i);
    assign word = l1_pkg::addr_word(addr_i);

    // Read is combinational for the addressed set and way
    assign rd_line_o = mem_q[set][way_i];

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            mem_q[set][way_i].flat <= fill_line_i.flat;
        end else if (word_wr_i) begin
            mem_q[set][way_i].words[word] <= word_data_i;
        end
    end

    a_no_wr_fill: assert property (@(posedge clk_i) !(word_wr_i && fill_i));

endmodule

//--- l1_tag_store.sv
`timescale 1ns/1ns

module l1_tag_store (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic [l1_pkg::ADDR_W-1:0]   lookup_addr_i,
    input  logic                        fill_i,
    input  logic                        dirty_i,
    input  logic [l1_pkg::WAY_W-1:0]    way_i,
    output logic                        hit_o,
    output logic [l1_pkg::WAY_W-1:0]    hit_way_o,
    output logic [l1_pkg::WAY_W-1:0]    victim_way_o,
    output logic                        victim_dirty_o,
    output logic [l1_pkg::TAG_W-1:0]    victim_tag_o
);

    logic [l1_pkg::WAYS-1:0]   valid_q [l1_pkg::SETS];
    logic [l1_pkg::WAYS-1:0]   dirty_q [l1_pkg::SETS];
    logic [l1_pkg::TAG_W-1:0]  tag_q   [l1_pkg::SETS][l1_pkg::WAYS];
    logic [l1_pkg::WAY_W-1:0]  rr_q    [l1_pkg::SETS];

    logic [l1_pkg::SET_W-1:0]  set;
    logic [l1_pkg::TAG_W-1:0]  tag;
    logic [l1_pkg::WAYS-1:0]   hit_vec;

    assign set = l1_pkg::addr_set(lookup_addr_i);
    assign tag = l1_pkg::addr_tag(lookup_addr_i);

    always_comb begin
        hit_way_o = '0;
        for (int w = 0; w < l1_pkg::WAYS; w++) begin
            hit_vec[w] = valid_q[set][w] && (tag_q[set][w] == tag);
            if (hit_vec[w]) begin
                hit_way_o = l1_pkg::WAY_W'(w);
            end
        end
    end

    assign hit_o = |hit_vec;

    // Lowest invalid way first and the round-robin pointer once the set is full
    always_comb begin
        victim_way_o = rr_q[set];
        for (int w = l1_pkg::WAYS - 1; w >= 0; w--) begin
            if (!valid_q[set][w]) begin
                victim_way_o = l1_pkg::WAY_W'(w);
            end
        end
    end

    assign victim_dirty_o = dirty_q[set][victim_way_o];
    assign victim_tag_o   = tag_q[set][victim_way_o];

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int s = 0; s < l1_pkg::SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                rr_q[s]    <= '0;
            end
        end else if (fill_i) begin
            valid_q[set][way_i] <= 1'b1;
            dirty_q[set][way_i] <= 1'b0;
            rr_q[set]           <= way_i + l1_pkg::WAY_W'(1);
        end else if (dirty_i) begin
            dirty_q[set][way_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            tag_q[set][way_i] <= tag;
        end
    end

    a_one_hit: assert property (@(posedge clk_i) disable iff (!rstn_i) $onehot0(hit_vec));

endmodule

//--- l1_ctrl.sv
`timescale 1ns/1ns

module l1_ctrl (
    input  logic                        clk_i,
    input  logic                        rstn_i,

    input  logic                        req_valid_i,
    input  logic                        req_write_i,
    input  logic [l1_pkg::ADDR_W-1:0]   req_addr_i,
    input  logic [l1_pkg::DATA_W-1:0]   req_wdata_i,
    output logic                        req_ready_o,
    output logic                        rsp_valid_o,
    output logic [l1_pkg::DATA_W-1:0]   rsp_rdata_o,
    input  logic                        rsp_ready_i,

    output logic                        bus_req_valid_o,
    output logic                        bus_req_write_o,
    output logic [l1_pkg::ADDR_W-1:0]   bus_req_addr_o,
    output l1_pkg::line_u               bus_req_line_o,
    input  logic                        bus_req_ready_i,
    input  logic                        bus_rsp_valid_i,
    input  l1_pkg::line_u               bus_rsp_line_i,
    output logic                        bus_rsp_ready_o,

    // Tag store results for the set of lookup_addr_o
    input  logic                        hit_i,
    input  logic [l1_pkg::WAY_W-1:0]    hit_way_i,
    input  logic [l1_pkg::WAY_W-1:0]    victim_way_i,
    input  logic                        victim_dirty_i,
    input  logic [l1_pkg::TAG_W-1:0]    victim_tag_i,
    input  l1_pkg::line_u               rd_line_i,

    output logic [l1_pkg::ADDR_W-1:0]   lookup_addr_o,
    output logic                        tag_fill_o,
    output logic                        tag_dirty_o,
    output logic [l1_pkg::WAY_W-1:0]    way_o,
    output logic                        word_wr_o,
    output logic [l1_pkg::DATA_W-1:0]   word_data_o,
    output logic                        line_fill_o,
    output l1_pkg::line_u               fill_line_o
);

    logic [l1_pkg::STATE_W-1:0] state_q;

    // Accepted request
    logic                       req_write_q;
    logic [l1_pkg::ADDR_W-1:0]  req_addr_q;
    logic [l1_pkg::DATA_W-1:0]  req_wdata_q;
    logic [l1_pkg::WAY_W-1:0]   way_q;

    logic                       rsp_valid_q;
    logic [l1_pkg::DATA_W-1:0]  rsp_rdata_q;

    logic                       bus_valid_q;
    logic                       bus_write_q;
    logic [l1_pkg::ADDR_W-1:0]  bus_addr_q;
    l1_pkg::line_u              bus_line_q;

    logic                       in_lookup;
    logic                       write_hit;
    logic                       fill_done;
    logic [l1_pkg::ADDR_W-1:0]  req_line_addr;

    assign in_lookup     = state_q == l1_pkg::STATE_W'(l1_pkg::ST_LOOKUP);
    assign write_hit     = in_lookup && hit_i && req_write_q;
    assign req_line_addr = l1_pkg::line_addr(l1_pkg::addr_tag(req_addr_q),
                                             l1_pkg::addr_set(req_addr_q));

    assign req_ready_o     = state_q == l1_pkg::STATE_W'(l1_pkg::ST_IDLE);
    assign rsp_valid_o     = rsp_valid_q;
    assign rsp_rdata_o     = rsp_rdata_q;
    assign bus_req_valid_o = bus_valid_q;
    assign bus_req_write_o = bus_write_q;
    assign bus_req_addr_o  = bus_addr_q;
    assign bus_req_line_o  = bus_line_q;
    assign bus_rsp_ready_o = state_q == l1_pkg::STATE_W'(l1_pkg::ST_FILL_WAIT);
    assign fill_done       = bus_rsp_valid_i && bus_rsp_ready_o;

    assign lookup_addr_o = req_addr_q;
    assign word_data_o   = req_wdata_q;
    assign word_wr_o     = write_hit;
    assign tag_dirty_o   = write_hit;
    assign tag_fill_o    = fill_done;
    assign line_fill_o   = fill_done;
    assign fill_line_o   = bus_rsp_line_i;

    // In lookup the victim way is read so a dirty line can go straight to the bus
    always_comb begin
        way_o = way_q;
        if (in_lookup) begin
            way_o = hit_i ? hit_way_i : victim_way_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q     <= l1_pkg::STATE_W'(l1_pkg::ST_IDLE);
            rsp_valid_q <= 1'b0;
            bus_valid_q <= 1'b0;
        end else begin
            case (state_q)
                l1_pkg::STATE_W'(l1_pkg::ST_IDLE): begin
                    if (req_valid_i && req_ready_o) begin
                        req_write_q <= req_write_i;
                        req_addr_q  <= req_addr_i;
                        req_wdata_q <= req_wdata_i;
                        state_q     <= l1_pkg::STATE_W'(l1_pkg::ST_LOOKUP);
                    end
                end
                l1_pkg::STATE_W'(l1_pkg::ST_LOOKUP): begin
                    if (hit_i) begin
                        if (req_write_q) begin
                            state_q <= l1_pkg::STATE_W'(l1_pkg::ST_IDLE);
                        end else begin
                            rsp_valid_q <= 1'b1;
                            rsp_rdata_q <= rd_line_i.words[l1_pkg::addr_word(req_addr_q)];
                            state_q     <= l1_pkg::STATE_W'(l1_pkg::ST_RESPOND);
                        end
                    end else begin
                        way_q       <= victim_way_i;
                        bus_valid_q <= 1'b1;
                        if (victim_dirty_i) begin
                            bus_write_q <= 1'b1;
                            bus_addr_q  <= l1_pkg::line_addr(victim_tag_i,
                                                             l1_pkg::addr_set(req_addr_q));
                            bus_line_q  <= rd_line_i;
                            state_q     <= l1_pkg::STATE_W'(l1_pkg::ST_WB_REQ);
                        end else begin
                            bus_write_q <= 1'b0;
                            bus_addr_q  <= req_line_addr;
                            state_q     <= l1_pkg::STATE_W'(l1_pkg::ST_FILL_REQ);
                        end
                    end
                end
                l1_pkg::STATE_W'(l1_pkg::ST_RESPOND): begin
                    if (rsp_ready_i) begin
                        rsp_valid_q <= 1'b0;
                        state_q     <= l1_pkg::STATE_W'(l1_pkg::ST_IDLE);
                    end
                end
                l1_pkg::STATE_W'(l1_pkg::ST_WB_REQ): begin
                    // Refill read follows the taken write-back without a gap
                    if (bus_req_ready_i) begin
                        bus_write_q <= 1'b0;
                        bus_addr_q  <= req_line_addr;
                        state_q     <= l1_pkg::STATE_W'(l1_pkg::ST_FILL_REQ);
                    end
                end
                l1_pkg::STATE_W'(l1_pkg::ST_FILL_REQ): begin
                    if (bus_req_ready_i) begin
                        bus_valid_q <= 1'b0;
                        state_q     <= l1_pkg::STATE_W'(l1_pkg::ST_FILL_WAIT);
                    end
                end
                l1_pkg::STATE_W'(l1_pkg::ST_FILL_WAIT): begin
                    // Repeat the lookup which now hits the filled way
                    if (fill_done) begin
                        state_q <= l1_pkg::STATE_W'(l1_pkg::ST_LOOKUP);
                    end
                end
                default: begin
                    state_q <= l1_pkg::STATE_W'(l1_pkg::ST_IDLE);
                end
            endcase
        end
    end

    a_rsp_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_rdata_o));

    a_bus_req_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        bus_req_valid_o && !bus_req_ready_i |=> bus_req_valid_o && $stable(bus_req_addr_o));

endmodule

//--- l1_cache_top.sv
`timescale 1ns/1ns

module l1_cache_top (
    input  logic                        clk_i,
    input  logic                        rstn_i,

    // Processor request and response
    input  logic                        req_valid_i,
    input  logic                        req_write_i,
    input  logic [l1_pkg::ADDR_W-1:0]   req_addr_i,
    input  logic [l1_pkg::DATA_W-1:0]   req_wdata_i,
    output logic                        req_ready_o,
    output logic                        rsp_valid_o,
    output logic [l1_pkg::DATA_W-1:0]   rsp_rdata_o,
    input  logic                        rsp_ready_i,

    // Memory bus
    output logic                        bus_req_valid_o,
    output logic                        bus_req_write_o,
    output logic [l1_pkg::ADDR_W-1:0]   bus_req_addr_o,
    output l1_pkg::line_u               bus_req_line_o,
    input  logic                        bus_req_ready_i,
    input  logic                        bus_rsp_valid_i,
    input  l1_pkg::line_u               bus_rsp_line_i,
    output logic                        bus_rsp_ready_o
);

    logic [l1_pkg::ADDR_W-1:0] lookup_addr;
    logic                      tag_fill;
    logic                      tag_dirty;
    logic [l1_pkg::WAY_W-1:0]  way;
    logic                      word_wr;
    logic [l1_pkg::DATA_W-1:0] word_data;
    logic                      line_fill;
    l1_pkg::line_u             fill_line;
    l1_pkg::line_u             rd_line;

    logic                      hit;
    logic [l1_pkg::WAY_W-1:0]  hit_way;
    logic [l1_pkg::WAY_W-1:0]  victim_way;
    logic                      victim_dirty;
    logic [l1_pkg::TAG_W-1:0]  victim_tag;

    l1_ctrl i_l1_ctrl (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .req_valid_i     (req_valid_i),
        .req_write_i     (req_write_i),
        .req_addr_i      (req_addr_i),
        .req_wdata_i     (req_wdata_i),
        .req_ready_o     (req_ready_o),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_rdata_o     (rsp_rdata_o),
        .rsp_ready_i     (rsp_ready_i),
        .bus_req_valid_o (bus_req_valid_o),
        .bus_req_write_o (bus_req_write_o),
        .bus_req_addr_o  (bus_req_addr_o),
        .bus_req_line_o  (bus_req_line_o),
        .bus_req_ready_i (bus_req_ready_i),
        .bus_rsp_valid_i (bus_rsp_valid_i),
        .bus_rsp_line_i  (bus_rsp_line_i),
        .bus_rsp_ready_o (bus_rsp_ready_o),
        .hit_i           (hit),
        .hit_way_i       (hit_way),
        .victim_way_i    (victim_way),
        .victim_dirty_i  (victim_dirty),
        .victim_tag_i    (victim_tag),
        .rd_line_i       (rd_line),
        .lookup_addr_o   (lookup_addr),
        .tag_fill_o      (tag_fill),
        .tag_dirty_o     (tag_dirty),
        .way_o           (way),
        .word_wr_o       (word_wr),
        .word_data_o     (word_data),
        .line_fill_o     (line_fill),
        .fill_line_o     (fill_line)
    );

    l1_tag_store i_l1_tag_store (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .lookup_addr_i  (lookup_addr),
        .fill_i         (tag_fill),
        .dirty_i        (tag_dirty),
        .way_i          (way),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag)
    );

    l1_line_store i_l1_line_store (
        .clk_i       (clk_i),
        .addr_i      (lookup_addr),
        .way_i       (way),
        .word_wr_i   (word_wr),
        .word_data_i (word_data),
        .fill_i      (line_fill),
        .fill_line_i (fill_line),
        .rd_line_o   (rd_line)
    );

endmodule

//--- tb_mem_model.sv
`timescale 1ns/1ns

module tb_mem_model (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        bus_req_valid_i,
    input  logic                        bus_req_write_i,
    input  logic [l1_pkg::ADDR_W-1:0]   bus_req_addr_i,
    input  l1_pkg::line_u               bus_req_line_i,
    output logic                        bus_req_ready_o,
    output logic                        bus_rsp_valid_o,
    output l1_pkg::line_u               bus_rsp_line_o,
    input  logic                        bus_rsp_ready_i,
    // Processor writes as they are accepted
    input  logic                        proc_wr_i,
    input  logic [l1_pkg::ADDR_W-1:0]   proc_addr_i,
    input  logic [l1_pkg::DATA_W-1:0]   proc_data_i,
    output l1_pkg::line_u               shadow_line_o
);

    localparam int MEM_WORDS = 2 ** (l1_pkg::ADDR_W - 2);

    logic [l1_pkg::DATA_W-1:0] mem    [MEM_WORDS];
    logic [l1_pkg::DATA_W-1:0] shadow [MEM_WORDS];
    logic [1:0]                req_wait;
    logic [1:0]                rsp_wait;
    logic                      fill_pending;
    logic [l1_pkg::ADDR_W-1:0] fill_addr;

    function automatic logic [l1_pkg::ADDR_W-3:0] word_index(
        input logic [l1_pkg::ADDR_W-1:0] addr, input int w);
        return {addr[l1_pkg::ADDR_W-1:l1_pkg::OFFSET_W], l1_pkg::WORD_SEL_W'(w)};
    endfunction

    // Expected content of the line currently on the bus request
    always_comb begin
        for (int w = 0; w < l1_pkg::WORDS_PER_LINE; w++) begin
            shadow_line_o.words[w] = shadow[word_index(bus_req_addr_i, w)];
        end
    end

    always @(posedge clk_i) begin
        if (!rstn_i) begin
            bus_req_ready_o <= 1'b0;
            bus_rsp_valid_o <= 1'b0;
            bus_rsp_line_o  <= '0;
            fill_pending    <= 1'b0;
            fill_addr       <= '0;
            req_wait        <= 2'($urandom_range(3, 0));
            rsp_wait        <= 2'd0;
            // Word at byte address A starts as C0DE in the upper half and A below
            for (int a = 0; a < MEM_WORDS; a++) begin
                mem[a]    <= {16'hC0DE, 16'(a * 4)};
                shadow[a] <= {16'hC0DE, 16'(a * 4)};
            end
        end else begin
            if (proc_wr_i) begin
                shadow[proc_addr_i[l1_pkg::ADDR_W-1:2]] <= proc_data_i;
            end
            if (bus_req_valid_i && bus_req_ready_o) begin
                bus_req_ready_o <= 1'b0;
                req_wait        <= 2'($urandom_range(3, 0));
                if (bus_req_write_i) begin
                    for (int w = 0; w < l1_pkg::WORDS_PER_LINE; w++) begin
                        mem[word_index(bus_req_addr_i, w)] <= bus_req_line_i.words[w];
                    end
                end else begin
                    fill_pending <= 1'b1;
                    fill_addr    <= bus_req_addr_i;
                    rsp_wait     <= 2'($urandom_range(3, 0));
                end
            end else if (bus_req_valid_i) begin
                if (req_wait == 2'd0) begin
                    bus_req_ready_o <= 1'b1;
                end else begin
                    req_wait <= req_wait - 2'd1;
                end
            end
            if (bus_rsp_valid_o && bus_rsp_ready_i) begin
                bus_rsp_valid_o <= 1'b0;
                fill_pending    <= 1'b0;
            end else if (fill_pending && !bus_rsp_valid_o) begin
                if (rsp_wait == 2'd0) begin
                    bus_rsp_valid_o <= 1'b1;
                    for (int w = 0; w < l1_pkg::WORDS_PER_LINE; w++) begin
                        bus_rsp_line_o.words[w] <= mem[word_index(fill_addr, w)];
                    end
                end else begin
                    rsp_wait <= rsp_wait - 2'd1;
                end
            end
        end
    end

endmodule

//--- tb_l1_cache.sv
`timescale 1ns/1ns

module tb_l1_cache;

    logic                      clk_i;
    logic                      rstn_i;
    logic                      req_valid_i;
    logic                      req_write_i;
    logic [l1_pkg::ADDR_W-1:0] req_addr_i;
    logic [l1_pkg::DATA_W-1:0] req_wdata_i;
    logic                      req_ready_o;
    logic                      rsp_valid_o;
    logic [l1_pkg::DATA_W-1:0] rsp_rdata_o;
    logic                      rsp_ready_i;
    logic                      bus_req_valid_o;
    logic                      bus_req_write_o;
    logic [l1_pkg::ADDR_W-1:0] bus_req_addr_o;
    l1_pkg::line_u             bus_req_line_o;
    logic                      bus_req_ready_i;
    logic                      bus_rsp_valid_i;
    l1_pkg::line_u             bus_rsp_line_i;
    logic                      bus_rsp_ready_o;

    logic                      proc_wr;
    l1_pkg::line_u             shadow_line;
    int unsigned               cycles;
    int unsigned               cycle_limit;
    int unsigned               bus_reads;
    logic [l1_pkg::ADDR_W-1:0] last_rd_addr;
    bit                        seen [int];

    logic                      op_q    [$];
    logic [l1_pkg::ADDR_W-1:0] addr_q  [$];
    logic [l1_pkg::DATA_W-1:0] wdata_q [$];
    logic [l1_pkg::DATA_W-1:0] exp_q   [$];

    l1_cache_top i_l1_cache_top (.*);

    assign proc_wr = req_valid_i && req_ready_o && req_write_i;

    tb_mem_model i_mem_model (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .bus_req_valid_i (bus_req_valid_o),
        .bus_req_write_i (bus_req_write_o),
        .bus_req_addr_i  (bus_req_addr_o),
        .bus_req_line_i  (bus_req_line_o),
        .bus_req_ready_o (bus_req_ready_i),
        .bus_rsp_valid_o (bus_rsp_valid_i),
        .bus_rsp_line_o  (bus_rsp_line_i),
        .bus_rsp_ready_i (bus_rsp_ready_o),
        .proc_wr_i       (proc_wr),
        .proc_addr_i     (req_addr_i),
        .proc_data_i     (req_wdata_i),
        .shadow_line_o   (shadow_line)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string msg);
        abort_run($sformatf("CHECK FAILED at %0d ns: %s", $time, msg));
    endtask

    task automatic check_rdata(input logic [l1_pkg::DATA_W-1:0] got,
                               input logic [l1_pkg::DATA_W-1:0] exp,
                               input logic [l1_pkg::ADDR_W-1:0] addr);
        if (got !== exp) begin
            report_mismatch($sformatf("read of %h gave %h, expected %h", addr, got, exp));
        end
    endtask

    task automatic check_line(input l1_pkg::line_u got, input l1_pkg::line_u exp,
                              input logic [l1_pkg::ADDR_W-1:0] addr);
        if (got.flat !== exp.flat) begin
            report_mismatch($sformatf("write-back of %h gave %h, expected %h",
                                      addr, got.flat, exp.flat));
        end
    endtask

    task automatic run_op(input logic is_wr, input logic [l1_pkg::ADDR_W-1:0] addr,
                          input logic [l1_pkg::DATA_W-1:0] wdata,
                          input logic [l1_pkg::DATA_W-1:0] exp);
        int unsigned               lat;
        int unsigned               reads_before;
        logic [l1_pkg::ADDR_W-1:0] line;
        logic [l1_pkg::DATA_W-1:0] held;
        line = {addr[l1_pkg::ADDR_W-1:l1_pkg::OFFSET_W], l1_pkg::OFFSET_W'(0)};
        req_valid_i <= 1'b1;
        req_write_i <= is_wr;
        req_addr_i  <= addr;
        req_wdata_i <= wdata;
        @(posedge clk_i);
        while (!req_ready_o) @(posedge clk_i);
        req_valid_i  <= 1'b0;
        reads_before = bus_reads;
        lat          = 0;
        if (is_wr) begin
            @(posedge clk_i);
            lat++;
            while (!req_ready_o) begin
                @(posedge clk_i);
                lat++;
            end
        end else begin
            while (!rsp_valid_o) begin
                @(posedge clk_i);
                lat++;
            end
            // Stalled response must hold and block new requests
            while (!rsp_ready_i) begin
                held = rsp_rdata_o;
                @(posedge clk_i);
                if (!rsp_valid_o || rsp_rdata_o !== held || req_ready_o) begin
                    report_mismatch($sformatf("response to %h not held while stalled", addr));
                end
            end
            check_rdata(rsp_rdata_o, exp, addr);
        end
        if (bus_reads - reads_before > 1 ||
            (bus_reads != reads_before && last_rd_addr !== line)) begin
            report_mismatch($sformatf("bus reads for %h wrong, last at %h", addr, last_rd_addr));
        end
        if (!seen.exists(int'(line)) && bus_reads == reads_before) begin
            report_mismatch($sformatf("first access to line %h made no bus read", line));
        end
        if (bus_reads == reads_before && lat != 2) begin
            report_mismatch($sformatf("hit on %h took %0d cycles, expected 2", addr, lat));
        end
        seen[int'(line)] = 1'b1;
    endtask

    always @(posedge clk_i) begin
        rsp_ready_i <= ($urandom_range(3, 0) != 0);
    end

    always @(posedge clk_i) begin
        if (rstn_i && bus_req_valid_o && bus_req_ready_i) begin
            if (bus_req_write_o) begin
                check_line(bus_req_line_o, shadow_line, bus_req_addr_o);
            end else begin
                bus_reads    <= bus_reads + 1;
                last_rd_addr <= bus_req_addr_o;
            end
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            abort_run($sformatf("Timeout after %0d cycles, the cache stopped responding", cycles));
        end
    end

    initial begin
        int                        fd;
        string                     text;
        logic [7:0]                op;
        logic [l1_pkg::ADDR_W-1:0] a;
        logic [l1_pkg::DATA_W-1:0] d;
        logic [l1_pkg::DATA_W-1:0] e;
        void'($urandom(81142));
        rstn_i       = 1'b0;
        req_valid_i  = 1'b0;
        req_write_i  = 1'b0;
        req_addr_i   = '0;
        req_wdata_i  = '0;
        rsp_ready_i  = 1'b1;
        cycles       = 0;
        cycle_limit  = 0;
        bus_reads    = 0;
        last_rd_addr = '0;
        fd = $fopen("l1_testdata.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open l1_testdata.txt for reading");
        end
        while (!$feof(fd)) begin
            if ($fgets(text, fd) != 0 && $sscanf(text, "%h %h %h %h", op, a, d, e) == 4) begin
                op_q.push_back(op[0]);
                addr_q.push_back(a);
                wdata_q.push_back(d);
                exp_q.push_back(e);
            end
        end
        $fclose(fd);
        cycle_limit = 64 * op_q.size() + 100;
        repeat (10) @(posedge clk_i);
        rstn_i <= 1'b1;
        @(posedge clk_i);
        if (!req_ready_o || rsp_valid_o || bus_req_valid_o || bus_rsp_ready_o) begin
            report_mismatch("outputs after reset are not idle");
        end
        foreach (op_q[i]) begin
            run_op(op_q[i], addr_q[i], wdata_q[i], exp_q[i]);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- sources.f
l1_pkg.sv
l1_line_store.sv
l1_tag_store.sv
l1_ctrl.sv
l1_cache_top.sv
tb_mem_model.sv
tb_l1_cache.sv

//--- run_sim.sh
#!/bin/sh
# Build the L1 cache testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_l1_cache -f sources.f -o tb_l1_cache &&
./obj_dir/tb_l1_cache || exit 1

//--- l1_testdata.txt
# op addr wdata expected, all hex
# op 0 is a read checked against expected, op 1 is a write of wdata
0 0104 00000000 c0de0104
1 0108 12345678 00000000
0 0108 00000000 12345678
0 010c 00000000 c0de010c
1 0204 aaaa0001 00000000
1 0304 bbbb0002 00000000
1 0408 cccc0003 00000000
0 0108 00000000 12345678
0 0204 00000000 aaaa0001
0 0304 00000000 bbbb0002
0 0408 00000000 cccc0003
1 1230 5a5a5a5a 00000000
0 1230 00000000 5a5a5a5a
0 1234 00000000 c0de1234
0 ff0c 00000000 c0deff0c
